// ==== verilog/pmaPkg.sv ====
package pmaPkg;

  // physical address is PA bits 14..35
  localparam int PA_W   = 22;
  localparam int PAGE_W = 13;              // PA 14..26
  localparam int OFS_W  = PA_W - PAGE_W;   // PA 27..35
  localparam int LINE_W = 7;               // PA 27..33
  localparam int WORD_W = OFS_W - LINE_W;  // PA 34..35

  // address source codes, registered by the cycle selector
  localparam logic [2:0] SRC_VMA  = 3'd0;
  localparam logic [2:0] SRC_PT   = 3'd1;  // page table frame + vma offset
  localparam logic [2:0] SRC_BASE = 3'd2;  // user/exec base page reference
  localparam logic [2:0] SRC_CHAN = 3'd3;
  localparam logic [2:0] SRC_CCA  = 3'd4;  // sweep counter
  localparam logic [2:0] SRC_ERA  = 3'd5;

  // sweep starts at the last word of the last line
  localparam logic [OFS_W-1:0] SWEEP_LOAD = '1;

  typedef struct packed {
    logic [PAGE_W-1:0] page;
    logic [OFS_W-1:0]  offset;
  } pmaPaged_t;

  typedef struct packed {
    logic [PAGE_W-1:0] page;
    logic [LINE_W-1:0] line;
    logic [WORD_W-1:0] word;
  } pmaSweep_t;

  // one address word, two decodings
  typedef union packed {
    pmaPaged_t paged;
    pmaSweep_t sweep;
  } pmaAddr_t;

  typedef struct packed {
    logic eraGrant;
    logic pageRefill;
    logic chanGrant;
    logic ccaGrant;
    logic eboxGrant;
    logic eboxPaged;   // level, qualifies eboxGrant
  } pmaGrants_t;

  // one-hot, all zero when idle
  typedef struct packed {
    logic eraCyc;
    logic refillCyc;
    logic chanCyc;
    logic ccaCyc;
    logic eboxCyc;
  } pmaCycType_t;

  typedef struct packed {
    logic loadUbr;
    logic loadEbr;
    logic loadCca;
    logic ccaStep;
    logic allWords;    // level, sweep every word of a line
  } pmaRegLoad_t;

endpackage

// ==== verilog/pmaCycleSelect.sv ====
`timescale 1ns/1ps

module pmaCycleSelect (
  input  logic                clock,
  input  logic                rstN,
  input  pmaPkg::pmaGrants_t  grants,
  input  logic                readyToGo,
  input  logic                vmaUser,
  output pmaPkg::pmaCycType_t cycType,
  output logic [2:0]          srcSel,
  output logic                ubrSel
);

  import pmaPkg::*;

  pmaCycType_t cycNext;
  logic [2:0]  srcNext;
  logic        ubrNext;
  logic        eboxPagedCyc;

  assign eboxPagedCyc = grants.eboxGrant & grants.eboxPaged;

  // fixed priority, ERA first
  always_comb begin
    cycNext = '0;
    srcNext = SRC_VMA;   // idle cycle shows the vma
    ubrNext = ubrSel;
    if (grants.eraGrant) begin
      cycNext.eraCyc = 1'b1;
      srcNext        = SRC_ERA;
    end else if (grants.pageRefill) begin
      cycNext.refillCyc = 1'b1;
      srcNext           = SRC_BASE;
      ubrNext           = vmaUser;   // user or exec table
    end else if (grants.chanGrant) begin
      cycNext.chanCyc = 1'b1;
      srcNext         = SRC_CHAN;
    end else if (grants.ccaGrant) begin
      cycNext.ccaCyc = 1'b1;
      srcNext        = SRC_CCA;
    end else if (grants.eboxGrant) begin
      cycNext.eboxCyc = 1'b1;
      srcNext         = eboxPagedCyc ? SRC_PT : SRC_VMA;
    end
  end

  // cycle type holds while the cache is not ready
  always_ff @(posedge clock) begin
    if (!rstN) begin
      cycType <= '0;
      srcSel  <= SRC_VMA;
      ubrSel  <= 1'b0;
    end else if (readyToGo) begin
      cycType <= cycNext;
      srcSel  <= srcNext;
      ubrSel  <= ubrNext;
    end
  end

endmodule

// ==== verilog/pmaBaseRegs.sv ====
`timescale 1ns/1ps

module pmaBaseRegs (
  input  logic                clock,
  input  logic                rstN,
  input  pmaPkg::pmaAddr_t    vma,
  input  pmaPkg::pmaRegLoad_t regLoad,
  input  logic                ubrSel,
  input  logic                eraHold,
  input  pmaPkg::pmaAddr_t    pa,
  output pmaPkg::pmaAddr_t    baseAddr,
  output pmaPkg::pmaAddr_t    ccaAddr,
  output pmaPkg::pmaAddr_t    eraAddr,
  output logic                ccaDone
);

  import pmaPkg::*;

  logic [PAGE_W-1:0] ubrPage;
  logic [PAGE_W-1:0] ebrPage;
  pmaAddr_t          ccaReg;
  pmaAddr_t          eraReg;
  logic              lineZero;
  logic              wordZero;

  // user and exec base registers
  always_ff @(posedge clock) begin
    if (!rstN) begin
      ubrPage <= '0;
      ebrPage <= '0;
    end else begin
      if (regLoad.loadUbr) begin
        ubrPage <= vma.paged.page;
      end
      if (regLoad.loadEbr) begin
        ebrPage <= vma.paged.page;
      end
    end
  end

  // page table reference, base page + vma page index
  always_comb begin
    baseAddr.paged.page   = ubrSel ? ubrPage : ebrPage;
    baseAddr.paged.offset = vma.paged.offset;
  end

  // sweep counter, counts line/word down from all ones
  always_ff @(posedge clock) begin
    if (!rstN) begin
      ccaReg <= '0;
    end else if (regLoad.loadCca) begin
      ccaReg.paged.page   <= vma.paged.page;
      ccaReg.paged.offset <= SWEEP_LOAD;
    end else if (regLoad.ccaStep) begin
      {ccaReg.sweep.line, ccaReg.sweep.word} <=
        {ccaReg.sweep.line, ccaReg.sweep.word} - 1'b1;
    end
  end

  assign lineZero = (ccaReg.sweep.line == '0);
  assign wordZero = (ccaReg.sweep.word == '0);
  // word count only matters when sweeping every word
  assign ccaDone  = lineZero & (wordZero | ~regLoad.allWords);
  assign ccaAddr  = ccaReg;

  // error address follows pa until frozen
  always_ff @(posedge clock) begin
    if (!rstN) begin
      eraReg <= '0;
    end else if (!eraHold) begin
      eraReg <= pa;
    end
  end

  assign eraAddr = eraReg;

endmodule

// ==== verilog/pmaAddrMux.sv ====
`timescale 1ns/1ps

module pmaAddrMux (
  input  logic [2:0]       srcSel,
  input  pmaPkg::pmaAddr_t vma,
  input  pmaPkg::pmaAddr_t ptEntry,
  input  pmaPkg::pmaAddr_t baseAddr,
  input  pmaPkg::pmaAddr_t chanAddr,
  input  pmaPkg::pmaAddr_t ccaAddr,
  input  pmaPkg::pmaAddr_t eraAddr,
  output pmaPkg::pmaAddr_t pa,
  output logic             adrPar,
  output logic             pagePar
);

  import pmaPkg::*;

  pmaAddr_t pagedAddr;

  // frame from the page table, offset straight from the vma
  always_comb begin
    pagedAddr.paged.page   = ptEntry.paged.page;
    pagedAddr.paged.offset = vma.paged.offset;
  end

  always_comb begin
    unique case (srcSel)
      SRC_VMA:  pa = vma;
      SRC_PT:   pa = pagedAddr;
      SRC_BASE: pa = baseAddr;
      SRC_CHAN: pa = chanAddr;
      SRC_CCA:  pa = ccaAddr;
      SRC_ERA:  pa = eraAddr;
      default:  pa = vma;   // unused codes
    endcase
  end

  // odd parity over page and line, word bits excluded
  assign adrPar  = ~(^{pa.sweep.page, pa.sweep.line});
  assign pagePar = ^pa.paged.page;   // even, page only

endmodule

// ==== verilog/pmaTop.sv ====
`timescale 1ns/1ps

module pmaTop (
  input  logic                clock,
  input  logic                rstN,
  input  pmaPkg::pmaGrants_t  grants,
  input  logic                readyToGo,
  input  pmaPkg::pmaAddr_t    vma,
  input  logic                vmaUser,
  input  pmaPkg::pmaAddr_t    chanAddr,
  input  pmaPkg::pmaAddr_t    ptEntry,
  input  pmaPkg::pmaRegLoad_t regLoad,
  input  logic                eraHold,
  output pmaPkg::pmaAddr_t    pa,
  output pmaPkg::pmaCycType_t cycType,
  output logic                adrPar,
  output logic                pagePar,
  output logic                ccaDone
);

  import pmaPkg::*;

  logic [2:0] srcSel;
  logic       ubrSel;
  pmaAddr_t   baseAddr;
  pmaAddr_t   ccaAddr;
  pmaAddr_t   eraAddr;

  pmaCycleSelect i_cycSel (
    .clock     (clock),
    .rstN      (rstN),
    .grants    (grants),
    .readyToGo (readyToGo),
    .vmaUser   (vmaUser),
    .cycType   (cycType),
    .srcSel    (srcSel),
    .ubrSel    (ubrSel)
  );

  pmaBaseRegs i_baseRegs (
    .clock    (clock),
    .rstN     (rstN),
    .vma      (vma),
    .regLoad  (regLoad),
    .ubrSel   (ubrSel),
    .eraHold  (eraHold),
    .pa       (pa),        // fed back for error capture
    .baseAddr (baseAddr),
    .ccaAddr  (ccaAddr),
    .eraAddr  (eraAddr),
    .ccaDone  (ccaDone)
  );

  pmaAddrMux i_addrMux (
    .srcSel   (srcSel),
    .vma      (vma),
    .ptEntry  (ptEntry),
    .baseAddr (baseAddr),
    .chanAddr (chanAddr),
    .ccaAddr  (ccaAddr),
    .eraAddr  (eraAddr),
    .pa       (pa),
    .adrPar   (adrPar),
    .pagePar  (pagePar)
  );

endmodule

// ==== tests/pmaTb.sv ====
`timescale 1ns/1ps

module pmaTb;

  import pmaPkg::*;

  logic        clock = 1'b0;
  logic        rstN;
  pmaGrants_t  grants;
  logic        readyToGo;
  pmaAddr_t    vma;
  logic        vmaUser;
  pmaAddr_t    chanAddr;
  pmaAddr_t    ptEntry;
  pmaRegLoad_t regLoad;
  logic        eraHold;
  pmaAddr_t    pa;
  pmaCycType_t cycType;
  logic        adrPar;
  logic        pagePar;
  logic        ccaDone;

  int          seed = 32'h71b7_7e7f;
  int          cycleCount = 0;
  int          recNo = 0;
  int          fd;
  string       lineBuf;

  // one golden record
  int fGrants, fRdy, fVma, fUser, fChan, fPt, fLoad, fHold, fRep;
  int fPa, fCyc, fAdrPar, fPagePar, fDone, fMask;

  pmaTop i_dut (
    .clock     (clock),
    .rstN      (rstN),
    .grants    (grants),
    .readyToGo (readyToGo),
    .vma       (vma),
    .vmaUser   (vmaUser),
    .chanAddr  (chanAddr),
    .ptEntry   (ptEntry),
    .regLoad   (regLoad),
    .eraHold   (eraHold),
    .pa        (pa),
    .cycType   (cycType),
    .adrPar    (adrPar),
    .pagePar   (pagePar),
    .ccaDone   (ccaDone)
  );

  always #10 clock = ~clock;   // 20 ns period

  always @(posedge clock) begin
    cycleCount <= cycleCount + 1;
  end

  task automatic abortRun();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic failRun(input string why);
    $display("ERROR: %s", why);
    abortRun();
  endtask

  task automatic checkAddr(input string name, input pmaAddr_t exp, input pmaAddr_t act);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t ns: %s expected %h actual %h", $time, name, exp, act);
      abortRun();
    end
  endtask

  task automatic checkCyc(input string name, input pmaCycType_t exp, input pmaCycType_t act);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t ns: %s expected %b actual %b", $time, name, exp, act);
      abortRun();
    end
  endtask

  task automatic checkBit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t ns: %s expected %b actual %b", $time, name, exp, act);
      abortRun();
    end
  endtask

  // every edge counts against the cycle budget
  task automatic nextEdge();
    @(posedge clock);
    if (cycleCount > 5000) begin
      failRun("simulation ran past its cycle limit");
    end
  endtask

  task automatic waitReset();
    int i;
    for (i = 0; i < 20 && rstN !== 1'b1; i++) begin
      @(posedge clock);
    end
    if (rstN !== 1'b1) begin
      failRun("reset was never released");
    end
  endtask

  // ffffff in the golden file marks a don't-care address
  function automatic pmaAddr_t pickAddr(input int raw);
    if (raw == 32'h00ff_ffff) begin
      return pmaAddr_t'($random(seed));
    end
    return pmaAddr_t'(raw[PA_W-1:0]);
  endfunction

  task automatic runRecord();
    pmaRegLoad_t quietLoad;
    pmaAddr_t    expPa;
    logic        refAdr;
    logic        refPage;
    int          i;
    expPa   = pmaAddr_t'(fPa[PA_W-1:0]);
    refAdr  = ~(^{expPa.sweep.page, expPa.sweep.line});   // odd parity
    refPage = ^expPa.paged.page;
    if (refAdr !== fAdrPar[0] || refPage !== fPagePar[0]) begin
      failRun($sformatf("golden record %0d has parity inconsistent with its pa", recNo));
    end
    if (fRep < 1 || fRep > 1024) begin
      failRun($sformatf("golden record %0d has a bad repeat count", recNo));
    end
    nextEdge();
    grants    <= pmaGrants_t'(fGrants[5:0]);
    readyToGo <= fRdy[0];
    vma       <= pickAddr(fVma);
    vmaUser   <= fUser[0];
    chanAddr  <= pickAddr(fChan);
    ptEntry   <= pickAddr(fPt);
    regLoad   <= pmaRegLoad_t'(fLoad[4:0]);
    eraHold   <= fHold[0];
    for (i = 0; i < fRep; i++) begin
      nextEdge();
    end
    // drop the strobes but keep allWords and eraHold
    quietLoad          = '0;
    quietLoad.allWords = fLoad[0];
    readyToGo <= 1'b0;
    regLoad   <= quietLoad;
    @(negedge clock);
    if (fMask[0]) checkAddr("pa", expPa, pa);
    if (fMask[1]) checkCyc("cycType", pmaCycType_t'(fCyc[4:0]), cycType);
    if (fMask[2]) checkBit("adrPar", fAdrPar[0], adrPar);
    if (fMask[3]) checkBit("pagePar", fPagePar[0], pagePar);
    if (fMask[4]) checkBit("ccaDone", fDone[0], ccaDone);
  endtask

  initial begin
    rstN = 1'b0;
    repeat (2) @(posedge clock);
    rstN <= 1'b1;
  end

  initial begin
    int nFields;
    grants    = '0;
    readyToGo = 1'b0;
    vma       = '0;
    vmaUser   = 1'b0;
    chanAddr  = '0;
    ptEntry   = '0;
    regLoad   = '0;
    eraHold   = 1'b0;
    fd = $fopen("tests/pmaGolden.txt", "r");
    if (fd == 0) begin
      failRun("cannot open tests/pmaGolden.txt");
    end
    waitReset();
    while (!$feof(fd)) begin
      if (recNo > 200) begin
        failRun("golden file reading did not finish");
      end
      lineBuf = "";
      void'($fgets(lineBuf, fd));
      if (lineBuf.len() < 2 || lineBuf.substr(0, 0) == "#") begin
        continue;
      end
      nFields = $sscanf(lineBuf, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        fGrants, fRdy, fVma, fUser, fChan, fPt, fLoad, fHold, fRep,
                        fPa, fCyc, fAdrPar, fPagePar, fDone, fMask);
      if (nFields != 15) begin
        failRun($sformatf("golden line after record %0d is malformed", recNo));
      end
      recNo++;
      runRecord();
    end
    $fclose(fd);
    if (recNo > 0) begin
      $display("records checked: %0d", recNo);
      $display("TEST RESULT: PASS");
    end else begin
      $display("ERROR: no golden records were checked");
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== pmaTop.f ====
verilog/pmaPkg.sv
verilog/pmaCycleSelect.sv
verilog/pmaBaseRegs.sv
verilog/pmaAddrMux.sv
verilog/pmaTop.sv
tests/pmaTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# build and run the PMA testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wall -Wno-fatal \
  -f pmaTop.f --top-module pmaTb -o pmaSim

simOut=$(./obj_dir/pmaSim)
echo "$simOut"

if echo "$simOut" | grep -q "TEST RESULT: PASS"; then
  exit 0
else
  exit 1
fi

// ==== tests/pmaGolden.txt ====
# stimulus: grants rdy vma user chan pt regLoad eraHold rep (ffffff = random)
# expected: pa cycType adrPar pagePar ccaDone mask(0 pa,1 cyc,2 adr,3 page,4 done)
00 0 000200 0 ffffff ffffff 00 0 001 000200 00 0 1 1 1f
02 1 000c04 0 ffffff ffffff 00 0 001 000c04 01 0 0 1 1f
03 1 000c07 0 ffffff 2001ff 00 0 001 200007 01 1 1 1 1f
08 0 000c07 0 ffffff 2001ff 00 0 001 200007 01 1 1 1 1f
00 1 002000 0 ffffff ffffff 10 0 001 002000 00 0 1 1 1f
00 1 004000 0 ffffff ffffff 08 0 001 004000 00 0 1 1 1f
10 1 000024 1 ffffff ffffff 00 0 001 002024 08 0 1 1 1f
10 1 000024 0 ffffff ffffff 00 0 001 004024 08 0 1 1 1f
04 1 006000 0 ffffff ffffff 04 0 001 0061ff 02 0 0 0 1f
04 1 ffffff 0 ffffff ffffff 02 0 001 0061fe 02 0 0 0 1f
04 1 ffffff 0 ffffff ffffff 02 0 1fa 006004 02 0 0 0 1f
04 1 ffffff 0 ffffff ffffff 02 0 001 006003 02 1 0 1 1f
04 1 ffffff 0 ffffff ffffff 01 0 001 006003 02 1 0 0 1f
04 1 ffffff 0 ffffff ffffff 03 0 003 006000 02 1 0 1 1f
08 1 ffffff 0 100008 ffffff 00 0 001 100008 04 1 1 1 1f
08 1 ffffff 0 000800 ffffff 00 1 001 000800 04 0 1 1 1f
3f 1 ffffff 0 ffffff ffffff 00 1 001 100008 10 1 1 1 1f
0c 1 ffffff 0 000800 ffffff 00 1 001 000800 04 0 1 1 1f
14 1 000000 1 ffffff ffffff 00 1 001 002000 08 0 1 1 1f
00 1 3ffffc 0 ffffff ffffff 00 0 001 3ffffc 00 1 1 1 1f
20 1 3ffffc 0 ffffff ffffff 00 0 001 3ffffc 10 1 1 1 1f
